//--- src/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// raster geometry, small enough for quick simulation
`define H_ACTIVE 16
`define H_TOTAL 24  // 8 blanking pixels per line

`define V_ACTIVE 4
`define V_TOTAL 6   // 2 blanking lines per frame

// vsync starts on the first blanking line
`define VS_LINES 1

// pixels stored per frame bank
`define FRAME_PIXELS (`H_ACTIVE * `V_ACTIVE)

`endif

//--- src/video_pkg.sv
package video_pkg;

    // rgb565 pixel, red in the top bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pixel_t;

    // per-pixel operation of the processing stage
    typedef enum logic [1:0] {
        MODE_PASS   = 2'd0,
        MODE_INVERT = 2'd1,
        MODE_GRAY   = 2'd2,
        MODE_PASS2  = 2'd3  // same as pass
    } proc_mode_t;

endpackage

//--- src/fb_pkg.sv
`include "video_cfg.svh"

package fb_pkg;

    // write side of the frame buffer
    typedef enum logic [1:0] {
        FB_WAIT_VS = 2'd0,  // idle until the first vsync
        FB_FILL    = 2'd1,
        FB_DROP    = 2'd2   // overrun, frame discarded
    } fb_state_t;

    // pixel address within one bank
    typedef logic [$clog2(`FRAME_PIXELS)-1:0] fb_addr_t;

endpackage

//--- src/video_timing.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_timing (
    input  logic       clk,
    input  logic       reset,
    output logic [4:0] x,
    output logic [2:0] y,
    output logic       de,
    output logic       vs
);

    logic [4:0] x_next;
    logic [2:0] y_next;

    // raster position of the coming cycle
    always_comb begin
        x_next = x + 5'd1;
        y_next = y;
        if (x == 5'(`H_TOTAL - 1)) begin
            x_next = '0;
            y_next = (y == 3'(`V_TOTAL - 1)) ? 3'd0 : y + 3'd1;
        end
    end

    // de and vs are decoded from the next position so they line up with x and y
    always_ff @(posedge clk) begin
        if (reset) begin
            x  <= 5'(`H_TOTAL - 1);  // first edge out of reset lands on 0,0
            y  <= 3'(`V_TOTAL - 1);
            de <= 1'b0;
            vs <= 1'b0;
        end else begin
            x  <= x_next;
            y  <= y_next;
            de <= (x_next < 5'(`H_ACTIVE)) && (y_next < 3'(`V_ACTIVE));
            vs <= (y_next >= 3'(`V_ACTIVE)) &&
                  (y_next < 3'(`V_ACTIVE + `VS_LINES));  // whole first blanking line
        end
    end

endmodule

//--- src/pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen (
    input  logic              clk,
    input  logic              reset,
    input  logic [4:0]        x,
    input  logic [2:0]        y,
    input  logic              de,
    input  logic              vs,
    output logic              vi_vs,
    output logic              vi_de,
    output video_pkg::pixel_t vi_data
);

    logic [2:0]        bar;
    video_pkg::pixel_t bar_pixel;

    assign bar = x[3:1];  // eight bars, two columns each

    // bar bits pick red, green and blue; line number in green lsbs
    always_comb begin
        bar_pixel.r = {5{bar[2]}};
        bar_pixel.g = {{4{bar[1]}}, y[1:0]};
        bar_pixel.b = {5{bar[0]}};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            vi_vs <= 1'b0;
            vi_de <= 1'b0;
        end else begin
            vi_vs <= vs;
            vi_de <= de;
        end
    end

    always_ff @(posedge clk) begin
        vi_data <= de ? bar_pixel : '0;  // blank outside the active area
    end

endmodule

//--- src/pixel_proc.sv
`timescale 1ns/1ps

module pixel_proc (
    input  logic                  clk,
    input  logic                  reset,
    input  video_pkg::proc_mode_t proc_mode,
    input  logic                  vi_vs,
    input  logic                  vi_de,
    input  video_pkg::pixel_t     vi_data,
    output logic                  vp_vs,
    output logic                  vp_de,
    output video_pkg::pixel_t     vp_data
);

    logic [6:0]        gray_sum;
    logic [4:0]        gray;
    video_pkg::pixel_t proc_pixel;

    always_comb begin
        // green scaled down to 5 bits before averaging
        gray_sum = 7'(vi_data.r) + 7'(vi_data.g[5:1]) + 7'(vi_data.b);
        gray     = 5'(gray_sum / 7'd3);

        case (proc_mode)
            video_pkg::MODE_INVERT: begin
                proc_pixel = video_pkg::pixel_t'(~vi_data);
            end
            video_pkg::MODE_GRAY: begin
                proc_pixel.r = gray;
                proc_pixel.g = {gray, 1'b0};  // back to 6 bits
                proc_pixel.b = gray;
            end
            default: begin
                proc_pixel = vi_data;  // pass and pass2
            end
        endcase
    end

    // strobes follow the data by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            vp_vs <= 1'b0;
            vp_de <= 1'b0;
        end else begin
            vp_vs <= vi_vs;
            vp_de <= vi_de;
        end
    end

    always_ff @(posedge clk) begin
        vp_data <= proc_pixel;
    end

endmodule

//--- src/frame_buf_ctrl.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module frame_buf_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  logic              vp_vs,
    input  logic              vp_de,
    input  video_pkg::pixel_t vp_data,
    input  logic              vo_vs,
    input  logic              vo_de,
    output logic              wr_en,
    output logic              wr_bank,
    output fb_pkg::fb_addr_t  wr_addr,
    output video_pkg::pixel_t wr_data,
    output logic              rd_en,
    output logic              rd_bank,
    output fb_pkg::fb_addr_t  rd_addr,
    output logic              video_de
);

    localparam fb_pkg::fb_addr_t LAST_ADDR = fb_pkg::fb_addr_t'(`FRAME_PIXELS - 1);

    fb_pkg::fb_state_t state;
    logic              vp_vs_d;
    logic              vo_vs_d;
    logic              vp_vs_rise;
    logic              vo_vs_rise;
    logic              wr_full;      // last address of the bank written
    logic              done_bank;    // most recent complete bank
    logic              frame_valid;
    logic              rd_valid;     // validity sampled at output frame start

    assign vp_vs_rise = vp_vs & ~vp_vs_d;
    assign vo_vs_rise = vo_vs & ~vo_vs_d;

    assign wr_en   = (state == fb_pkg::FB_FILL) && vp_de && !wr_full;
    assign wr_data = vp_data;
    assign rd_en   = vo_de && rd_valid;

    // write side, bank swap on every complete frame
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= fb_pkg::FB_WAIT_VS;
            vp_vs_d     <= 1'b0;
            wr_bank     <= 1'b0;
            wr_addr     <= '0;
            wr_full     <= 1'b0;
            done_bank   <= 1'b0;
            frame_valid <= 1'b0;
        end else begin
            vp_vs_d <= vp_vs;
            if (vp_vs_rise) begin
                if (state == fb_pkg::FB_FILL && wr_full) begin
                    done_bank   <= wr_bank;  // publish
                    frame_valid <= 1'b1;
                    wr_bank     <= ~wr_bank;
                end
                state   <= fb_pkg::FB_FILL;
                wr_addr <= '0;
                wr_full <= 1'b0;
            end else if (state == fb_pkg::FB_FILL && vp_de) begin
                if (wr_full) begin
                    state <= fb_pkg::FB_DROP;  // pixel past the end of the bank
                end else if (wr_addr == LAST_ADDR) begin
                    wr_full <= 1'b1;
                end else begin
                    wr_addr <= wr_addr + 1'b1;
                end
            end
        end
    end

    // read side follows the output raster
    always_ff @(posedge clk) begin
        if (reset) begin
            vo_vs_d  <= 1'b0;
            rd_bank  <= 1'b0;
            rd_addr  <= '0;
            rd_valid <= 1'b0;
            video_de <= 1'b0;
        end else begin
            vo_vs_d  <= vo_vs;
            video_de <= rd_en;  // matches the memory read latency
            if (vo_vs_rise) begin
                rd_bank  <= done_bank;  // held for the whole output frame
                rd_valid <= frame_valid;
                rd_addr  <= '0;
            end else if (vo_de) begin
                rd_addr <= (rd_addr == LAST_ADDR) ? '0 : rd_addr + 1'b1;
            end
        end
    end

endmodule

//--- src/frame_mem.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module frame_mem (
    input  logic              clk,
    input  logic              wr_en,
    input  logic              wr_bank,
    input  fb_pkg::fb_addr_t  wr_addr,
    input  video_pkg::pixel_t wr_data,
    input  logic              rd_en,
    input  logic              rd_bank,
    input  fb_pkg::fb_addr_t  rd_addr,
    output video_pkg::pixel_t rd_data
);

    // two frame banks
    video_pkg::pixel_t mem [2][`FRAME_PIXELS];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // registered read, zero on idle cycles
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr];
        end else begin
            rd_data <= '0;
        end
    end

endmodule

//--- src/video_top.sv
`timescale 1ns/1ps

module video_top (
    input  logic                  clk,
    input  logic                  reset,
    input  video_pkg::proc_mode_t proc_mode,
    output logic                  vo_vs,
    output logic                  vo_de,
    output logic                  video_de,
    output video_pkg::pixel_t     video_data
);

    // input raster
    logic [4:0]        tin_x;
    logic [2:0]        tin_y;
    logic              tin_de;
    logic              tin_vs;

    // pattern and processing stages
    logic              vi_vs;
    logic              vi_de;
    video_pkg::pixel_t vi_data;
    logic              vp_vs;
    logic              vp_de;
    video_pkg::pixel_t vp_data;

    // frame buffer ports
    logic              wr_en;
    logic              wr_bank;
    fb_pkg::fb_addr_t  wr_addr;
    video_pkg::pixel_t wr_data;
    logic              rd_en;
    logic              rd_bank;
    fb_pkg::fb_addr_t  rd_addr;

    video_timing timing_in (
        .clk   (clk),
        .reset (reset),
        .x     (tin_x),
        .y     (tin_y),
        .de    (tin_de),
        .vs    (tin_vs)
    );

    pattern_gen pattern_gen_i (
        .clk     (clk),
        .reset   (reset),
        .x       (tin_x),
        .y       (tin_y),
        .de      (tin_de),
        .vs      (tin_vs),
        .vi_vs   (vi_vs),
        .vi_de   (vi_de),
        .vi_data (vi_data)
    );

    pixel_proc pixel_proc_i (
        .clk       (clk),
        .reset     (reset),
        .proc_mode (proc_mode),
        .vi_vs     (vi_vs),
        .vi_de     (vi_de),
        .vi_data   (vi_data),
        .vp_vs     (vp_vs),
        .vp_de     (vp_de),
        .vp_data   (vp_data)
    );

    frame_buf_ctrl frame_buf_ctrl_i (
        .clk      (clk),
        .reset    (reset),
        .vp_vs    (vp_vs),
        .vp_de    (vp_de),
        .vp_data  (vp_data),
        .vo_vs    (vo_vs),
        .vo_de    (vo_de),
        .wr_en    (wr_en),
        .wr_bank  (wr_bank),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_en    (rd_en),
        .rd_bank  (rd_bank),
        .rd_addr  (rd_addr),
        .video_de (video_de)
    );

    // read data goes straight out as the video pixel
    frame_mem frame_mem_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_bank (wr_bank),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_bank (rd_bank),
        .rd_addr (rd_addr),
        .rd_data (video_data)
    );

    // output raster, position not needed
    video_timing timing_out (
        .clk   (clk),
        .reset (reset),
        .x     (),
        .y     (),
        .de    (vo_de),
        .vs    (vo_vs)
    );

endmodule

//--- dv/video_asserts.sv
`timescale 1ns/1ps

module video_asserts (
    input logic              clk,
    input logic              reset,
    input logic              vo_vs,
    input logic              vo_de,
    input logic              video_de,
    input video_pkg::pixel_t video_data,
    input fb_pkg::fb_state_t fb_state
);

    int failures = 0;  // read by the testbench

    // a pixel only comes back for a read issued one cycle earlier
    de_after_read: assert property (@(posedge clk) disable iff (reset)
        video_de |-> $past(vo_de))
        else begin
            failures++;
            $error("video_de without vo_de on the previous cycle");
        end

    blank_data_zero: assert property (@(posedge clk) disable iff (reset)
        !video_de |-> (video_data == '0))
        else begin
            failures++;
            $error("video_data not zero while video_de is low");
        end

    // sync lies in blanking
    de_vs_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(vo_de && vo_vs))
        else begin
            failures++;
            $error("vo_de and vo_vs high together");
        end

    quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> (!vo_de && !vo_vs && !video_de))
        else begin
            failures++;
            $error("control output high during reset");
        end

    // the input raster never delivers more pixels than a bank holds
    no_overrun: assert property (@(posedge clk) disable iff (reset)
        fb_state != fb_pkg::FB_DROP)
        else begin
            failures++;
            $error("frame buffer dropped an overlong input frame");
        end

endmodule

//--- dv/video_tb.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_tb;

    logic                  clk;
    logic                  reset;
    video_pkg::proc_mode_t proc_mode;
    logic                  vo_vs;
    logic                  vo_de;
    logic                  video_de;
    video_pkg::pixel_t     video_data;

    // updated by the stimulus process just after a vo_vs rise
    logic                  check_en;
    video_pkg::proc_mode_t check_mode;
    int                    expected_checked;

    // comparing process state
    int                    pixels_checked;
    int                    de_count;
    int                    vo_de_count;
    logic                  vo_vs_prev;
    int                    vs_rises;

    // input frame 0 only arms the writer, frame 1 is published two cycles
    // after the second vo_vs, so reads start after the third
    localparam int FIRST_READ_VS = 3;

    video_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .proc_mode  (proc_mode),
        .vo_vs      (vo_vs),
        .vo_de      (vo_de),
        .video_de   (video_de),
        .video_data (video_data)
    );

    bind video_top video_asserts asserts_i (
        .clk        (clk),
        .reset      (reset),
        .vo_vs      (vo_vs),
        .vo_de      (vo_de),
        .video_de   (video_de),
        .video_data (video_data),
        .fb_state   (frame_buf_ctrl_i.state)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // colour bars, then the selected per-pixel operation
    function automatic logic [15:0] expect_pixel(input int x, input int y,
                                                 input video_pkg::proc_mode_t mode);
        int          bar;
        int          r;
        int          g;
        int          b;
        int          gray;
        logic [15:0] pix;
        bar = x / 2;
        r   = ((bar / 4) % 2 == 1) ? 31 : 0;
        g   = ((bar / 2) % 2 == 1) ? 60 : 0;  // four msbs of green
        g   = g + (y % 4);
        b   = (bar % 2 == 1) ? 31 : 0;
        case (mode)
            video_pkg::MODE_INVERT: begin
                pix = ~{r[4:0], g[5:0], b[4:0]};
            end
            video_pkg::MODE_GRAY: begin
                gray = (r + g / 2 + b) / 3;
                pix  = {gray[4:0], gray[4:0], 1'b0, gray[4:0]};
            end
            default: begin
                pix = {r[4:0], g[5:0], b[4:0]};
            end
        endcase
        return pix;
    endfunction

    // returns at the falling edge where vo_vs is first seen high
    task automatic wait_frame();
        int   cycles;
        logic seen_low;
        cycles   = 0;
        seen_low = 1'b0;
        while (!(seen_low && vo_vs)) begin
            if (!vo_vs) seen_low = 1'b1;
            @(negedge clk);
            cycles++;
            if (cycles > 2 * `H_TOTAL * `V_TOTAL) begin
                stop_on_error("timeout while waiting for a vo_vs rising edge");
            end
        end
    endtask

    // output frames trail input frames by two, so only the last two are checked
    task automatic run_hold(input video_pkg::proc_mode_t mode, input int frames);
        proc_mode = mode;
        repeat (frames - 2) wait_frame();
        check_mode = mode;
        check_en   = 1'b1;
        repeat (2) wait_frame();
        check_en = 1'b0;
        expected_checked += 2 * `FRAME_PIXELS;
    endtask

    always @(posedge clk) begin
        logic [15:0] got;
        logic [15:0] exp;
        int          px;
        int          py;
        int          de_expected;
        assert (dut_i.asserts_i.failures == 0)
            else stop_on_error("a bound assertion on the top level failed");
        if (reset) begin
            assert (!video_de) else stop_on_error("video_de high during reset");
            de_count       = 0;
            vo_de_count    = 0;
            pixels_checked = 0;
            vo_vs_prev     = 1'b0;
            vs_rises       = 0;
        end else begin
            if (vo_vs && !vo_vs_prev) begin  // end of an output frame
                assert (vo_de_count == `FRAME_PIXELS)
                    else stop_on_error($sformatf(
                        "Fail at time %0t: vo_de count got %0d expected %0d",
                        $time, vo_de_count, `FRAME_PIXELS));
                de_expected = (vs_rises >= FIRST_READ_VS) ? `FRAME_PIXELS : 0;
                assert (de_count == de_expected)
                    else stop_on_error($sformatf(
                        "Fail at time %0t: video_de count got %0d expected %0d",
                        $time, de_count, de_expected));
                vs_rises++;
                de_count    = 0;
                vo_de_count = 0;
            end
            vo_vs_prev = vo_vs;
            if (vo_de) vo_de_count++;
            if (video_de) begin
                px = de_count % `H_ACTIVE;
                py = de_count / `H_ACTIVE;
                if (check_en) begin
                    got = video_data;
                    exp = expect_pixel(px, py, check_mode);
                    assert (got == exp)
                        else stop_on_error($sformatf(
                            "Fail at time %0t: video_data got %h expected %h at x %0d y %0d",
                            $time, got, exp, px, py));
                    pixels_checked++;
                end
                de_count++;
            end
        end
    end

    initial begin
        int                    hold;
        video_pkg::proc_mode_t mode;
        void'($urandom(78113));
        reset            = 1'b1;
        proc_mode        = video_pkg::MODE_PASS;
        check_en         = 1'b0;
        check_mode       = video_pkg::MODE_PASS;
        expected_checked = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;

        wait_frame();  // first frame boundary after reset
        run_hold(video_pkg::MODE_PASS, 4);
        run_hold(video_pkg::MODE_INVERT, 4);
        run_hold(video_pkg::MODE_GRAY, 4);
        run_hold(video_pkg::MODE_PASS2, 4);

        // random modes, pass2 included
        repeat (6) begin
            mode = video_pkg::proc_mode_t'(2'($urandom % 4));
            hold = 4 + int'($urandom % 3);
            run_hold(mode, hold);
        end

        if (pixels_checked == expected_checked) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            stop_on_error($sformatf("Fail at time %0t: checked pixels got %0d expected %0d",
                                    $time, pixels_checked, expected_checked));
        end
    end

endmodule

//--- list.f
+incdir+src
src/video_pkg.sv
src/fb_pkg.sv
src/video_timing.sv
src/pattern_gen.sv
src/pixel_proc.sv
src/frame_buf_ctrl.sv
src/frame_mem.sv
src/video_top.sv
dv/video_asserts.sv
dv/video_tb.sv

//--- Makefile
TOP = video_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
